//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_axil_regs
RTL_TOP ?= axil_regs_top
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert -Wno-fatal

FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/axil_pkg.sv
`default_nettype none

package axil_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////

	// Byte address, eight words of four bytes plus decode room
	localparam int AXIL_ADDR_W = 8;
	localparam int AXIL_DATA_W = 32;
	// One strobe bit per data byte
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////

	// Word index taken from address bits above the low two
	localparam int REG_IDX_W = 3;
	localparam int NUM_REGS = 8;
	// Identification word, read-only at word 0
	localparam logic [AXIL_DATA_W-1:0] REG_ID_VALUE = 32'h5a11_0c01;

	////////////////////////////////////////////////////////////
	// Response codes
	////////////////////////////////////////////////////////////

	localparam logic [1:0] RESP_OKAY = 2'b00;
	// Exclusive okay, never produced by this slave
	localparam logic [1:0] RESP_EXOKAY = 2'b01;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	////////////////////////////////////////////////////////////
	// Monitor sizes
	////////////////////////////////////////////////////////////

	// Outstanding counter width
	localparam int OUTST_W = 4;
	// Cycles a pending response may stay absent
	localparam int MON_MAX_WAIT = 8;

endpackage

`default_nettype wire

//--- hw/axil_protocol_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module axil_protocol_monitor (
	input wire i_clk,
	input wire i_axi_reset_n,
	// Write address channel
	input wire i_awvalid,
	input wire i_awready,
	input wire [axil_pkg::AXIL_ADDR_W-1:0] i_awaddr,
	// Write data channel
	input wire i_wvalid,
	input wire i_wready,
	input wire [axil_pkg::AXIL_DATA_W-1:0] i_wdata,
	input wire [axil_pkg::AXIL_STRB_W-1:0] i_wstrb,
	// Write response channel
	input wire i_bvalid,
	input wire i_bready,
	input wire [1:0] i_bresp,
	// Read address channel
	input wire i_arvalid,
	input wire i_arready,
	input wire [axil_pkg::AXIL_ADDR_W-1:0] i_araddr,
	// Read data channel
	input wire i_rvalid,
	input wire i_rready,
	input wire [axil_pkg::AXIL_DATA_W-1:0] i_rdata,
	input wire [1:0] i_rresp,
	// Outstanding counts
	output logic [axil_pkg::OUTST_W-1:0] o_awr_outstanding,
	output logic [axil_pkg::OUTST_W-1:0] o_wr_outstanding,
	output logic [axil_pkg::OUTST_W-1:0] o_rd_outstanding
);

	logic aw_hs, w_hs, b_hs, ar_hs, r_hs;
	logic [axil_pkg::OUTST_W-1:0] wr_wait;
	logic [axil_pkg::OUTST_W-1:0] rd_wait;

	assign aw_hs = i_awvalid && i_awready;
	assign w_hs = i_wvalid && i_wready;
	assign b_hs = i_bvalid && i_bready;
	assign ar_hs = i_arvalid && i_arready;
	assign r_hs = i_rvalid && i_rready;

	////////////////////////////////////////////////////////////
	// Outstanding counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_awr_outstanding <= '0;
			o_wr_outstanding <= '0;
			o_rd_outstanding <= '0;
		end
		else
		begin
			// Address count, up on AW, down on B
			case ({aw_hs, b_hs})
				2'b10: o_awr_outstanding <= o_awr_outstanding + 1'b1;
				2'b01: o_awr_outstanding <= o_awr_outstanding - 1'b1;
				default: o_awr_outstanding <= o_awr_outstanding;
			endcase
			// Data count, up on W, down on B
			case ({w_hs, b_hs})
				2'b10: o_wr_outstanding <= o_wr_outstanding + 1'b1;
				2'b01: o_wr_outstanding <= o_wr_outstanding - 1'b1;
				default: o_wr_outstanding <= o_wr_outstanding;
			endcase
			case ({ar_hs, r_hs})
				2'b10: o_rd_outstanding <= o_rd_outstanding + 1'b1;
				2'b01: o_rd_outstanding <= o_rd_outstanding - 1'b1;
				default: o_rd_outstanding <= o_rd_outstanding;
			endcase
		end
	end

	// Cycles with a complete request owed and no response shown
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || i_bvalid || (o_awr_outstanding == '0)
			|| (o_wr_outstanding == '0))
			wr_wait <= '0;
		else
			wr_wait <= wr_wait + 1'b1;
		if (!i_axi_reset_n || i_rvalid || (o_rd_outstanding == '0))
			rd_wait <= '0;
		else
			rd_wait <= rd_wait + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Reset and stability rules
	////////////////////////////////////////////////////////////

	// Quiet bus in the cycle after reset
	assert property (@(posedge i_clk) !i_axi_reset_n |=>
		!(i_awvalid || i_wvalid || i_arvalid || i_bvalid || i_rvalid));

	// Stalled channels hold valid and payload
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_awvalid && !i_awready) |=> (i_awvalid && $stable(i_awaddr)));
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_wvalid && !i_wready) |=>
		(i_wvalid && $stable(i_wdata) && $stable(i_wstrb)));
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_arvalid && !i_arready) |=> (i_arvalid && $stable(i_araddr)));
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_bvalid && !i_bready) |=> (i_bvalid && $stable(i_bresp)));
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_rvalid && !i_rready) |=>
		(i_rvalid && $stable(i_rdata) && $stable(i_rresp)));

	////////////////////////////////////////////////////////////
	// Ordering and response rules
	////////////////////////////////////////////////////////////

	// Response only against a request already taken
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_bvalid |-> ((o_awr_outstanding != '0) && (o_wr_outstanding != '0)));
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_rvalid |-> (o_rd_outstanding != '0));

	// No exclusive okay on a non-exclusive port
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_bvalid |-> (i_bresp != axil_pkg::RESP_EXOKAY));
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_rvalid |-> (i_rresp != axil_pkg::RESP_EXOKAY));

	// Counters never saturate
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		!(&o_awr_outstanding) && !(&o_wr_outstanding) && !(&o_rd_outstanding));

	// Owed responses show up within a fixed window
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(wr_wait < axil_pkg::MON_MAX_WAIT) && (rd_wait < axil_pkg::MON_MAX_WAIT));

endmodule

`default_nettype wire

//--- hw/axil_reg_bank.sv
`timescale 1ns/100ps
`default_nettype none

module axil_reg_bank (
	input wire i_clk,
	input wire i_axi_reset_n,
	// One access per strobe cycle
	input wire i_acc_valid,
	input wire i_acc_write,
	input wire [axil_pkg::AXIL_ADDR_W-1:0] i_acc_addr,
	input wire [axil_pkg::AXIL_DATA_W-1:0] i_acc_wdata,
	input wire [axil_pkg::AXIL_STRB_W-1:0] i_acc_strb,
	// Registered result
	output logic o_res_valid,
	output logic o_res_write,
	output logic [axil_pkg::AXIL_DATA_W-1:0] o_res_rdata,
	output logic [1:0] o_res_resp
);

	// Word 0 has no storage, it is a constant
	logic [axil_pkg::AXIL_DATA_W-1:0] regs [1:axil_pkg::NUM_REGS-1];
	logic [axil_pkg::REG_IDX_W-1:0] idx;
	logic in_map;
	logic wr_en;
	logic [axil_pkg::AXIL_DATA_W-1:0] rd_word;
	logic [1:0] resp_code;

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	// Low two bits ignored
	assign idx = i_acc_addr[axil_pkg::REG_IDX_W+1:2];
	// Upper bits must be zero to hit the map
	assign in_map = (i_acc_addr[axil_pkg::AXIL_ADDR_W-1:axil_pkg::REG_IDX_W+2] == '0);
	// Writable words are 1 to 7
	assign wr_en = i_acc_valid && i_acc_write && in_map && (idx != '0);

	always_comb
	begin
		rd_word = '0;
		resp_code = axil_pkg::RESP_OKAY;
		if (!in_map)
		begin
			// Past the map, zero data
			resp_code = axil_pkg::RESP_DECERR;
		end
		else if (idx == '0)
		begin
			rd_word = axil_pkg::REG_ID_VALUE;
			// ID word refuses writes
			if (i_acc_write)
				resp_code = axil_pkg::RESP_SLVERR;
		end
		else
			rd_word = regs[idx];
	end

	////////////////////////////////////////////////////////////
	// Register array with byte strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			for (int i = 1; i < axil_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			// Merge selected bytes only
			for (int b = 0; b < axil_pkg::AXIL_STRB_W; b++)
				if (i_acc_strb[b])
					regs[idx][8*b +: 8] <= i_acc_wdata[8*b +: 8];
		end
	end

	////////////////////////////////////////////////////////////
	// Result register
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_res_valid <= 1'b0;
		else
			o_res_valid <= i_acc_valid;
	end

	always_ff @(posedge i_clk)
	begin
		o_res_write <= i_acc_write;
		o_res_rdata <= rd_word;
		o_res_resp <= resp_code;
	end

	// A full-strobe write lands whole in its word
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(wr_en && (i_acc_strb == '1)) |=> (regs[$past(idx)] == $past(i_acc_wdata)));

endmodule

`default_nettype wire

//--- hw/axil_regs_top.sv
`timescale 1ns/100ps
`default_nettype none

module axil_regs_top (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire i_awvalid,
	output logic o_awready,
	input wire [axil_pkg::AXIL_ADDR_W-1:0] i_awaddr,
	input wire i_wvalid,
	output logic o_wready,
	input wire [axil_pkg::AXIL_DATA_W-1:0] i_wdata,
	input wire [axil_pkg::AXIL_STRB_W-1:0] i_wstrb,
	output logic o_bvalid,
	input wire i_bready,
	output logic [1:0] o_bresp,
	input wire i_arvalid,
	output logic o_arready,
	input wire [axil_pkg::AXIL_ADDR_W-1:0] i_araddr,
	output logic o_rvalid,
	input wire i_rready,
	output logic [axil_pkg::AXIL_DATA_W-1:0] o_rdata,
	output logic [1:0] o_rresp,
	// Write address and read counts from the monitor
	output logic [axil_pkg::OUTST_W-1:0] o_wr_outstanding,
	output logic [axil_pkg::OUTST_W-1:0] o_rd_outstanding
);

	// Request to bank
	logic acc_valid;
	logic acc_write;
	logic [axil_pkg::AXIL_ADDR_W-1:0] acc_addr;
	logic [axil_pkg::AXIL_DATA_W-1:0] acc_wdata;
	logic [axil_pkg::AXIL_STRB_W-1:0] acc_strb;
	// Bank to response
	logic res_valid;
	logic res_write;
	logic [axil_pkg::AXIL_DATA_W-1:0] res_rdata;
	logic [1:0] res_resp;
	// Stall feedback
	logic b_busy;
	logic r_busy;

	axil_request_stage u_request (
		.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n),
		.i_awvalid(i_awvalid),
		.o_awready(o_awready),
		.i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid),
		.o_wready(o_wready),
		.i_wdata(i_wdata),
		.i_wstrb(i_wstrb),
		.i_arvalid(i_arvalid),
		.o_arready(o_arready),
		.i_araddr(i_araddr),
		.i_b_busy(b_busy),
		.i_r_busy(r_busy),
		.o_acc_valid(acc_valid),
		.o_acc_write(acc_write),
		.o_acc_addr(acc_addr),
		.o_acc_wdata(acc_wdata),
		.o_acc_strb(acc_strb)
	);

	axil_reg_bank u_bank (
		.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n),
		.i_acc_valid(acc_valid),
		.i_acc_write(acc_write),
		.i_acc_addr(acc_addr),
		.i_acc_wdata(acc_wdata),
		.i_acc_strb(acc_strb),
		.o_res_valid(res_valid),
		.o_res_write(res_write),
		.o_res_rdata(res_rdata),
		.o_res_resp(res_resp)
	);

	axil_resp_stage u_resp (
		.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n),
		.i_res_valid(res_valid),
		.i_res_write(res_write),
		.i_res_rdata(res_rdata),
		.i_res_resp(res_resp),
		.i_acc_valid(acc_valid),
		.i_acc_write(acc_write),
		.i_bready(i_bready),
		.i_rready(i_rready),
		.o_bvalid(o_bvalid),
		.o_bresp(o_bresp),
		.o_rvalid(o_rvalid),
		.o_rdata(o_rdata),
		.o_rresp(o_rresp),
		.o_b_busy(b_busy),
		.o_r_busy(r_busy)
	);

	// Passive, sees the port exactly as the master does
	axil_protocol_monitor u_monitor (
		.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n),
		.i_awvalid(i_awvalid),
		.i_awready(o_awready),
		.i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid),
		.i_wready(o_wready),
		.i_wdata(i_wdata),
		.i_wstrb(i_wstrb),
		.i_bvalid(o_bvalid),
		.i_bready(i_bready),
		.i_bresp(o_bresp),
		.i_arvalid(i_arvalid),
		.i_arready(o_arready),
		.i_araddr(i_araddr),
		.i_rvalid(o_rvalid),
		.i_rready(i_rready),
		.i_rdata(o_rdata),
		.i_rresp(o_rresp),
		.o_awr_outstanding(o_wr_outstanding),
		.o_wr_outstanding(),
		.o_rd_outstanding(o_rd_outstanding)
	);

endmodule

`default_nettype wire

//--- hw/axil_request_stage.sv
`timescale 1ns/100ps
`default_nettype none

module axil_request_stage (
	input wire i_clk,
	input wire i_axi_reset_n,
	// Write address channel
	input wire i_awvalid,
	output logic o_awready,
	input wire [axil_pkg::AXIL_ADDR_W-1:0] i_awaddr,
	// Write data channel
	input wire i_wvalid,
	output logic o_wready,
	input wire [axil_pkg::AXIL_DATA_W-1:0] i_wdata,
	input wire [axil_pkg::AXIL_STRB_W-1:0] i_wstrb,
	// Read address channel
	input wire i_arvalid,
	output logic o_arready,
	input wire [axil_pkg::AXIL_ADDR_W-1:0] i_araddr,
	// Back-pressure from the response stage
	input wire i_b_busy,
	input wire i_r_busy,
	// Access strobe to the register bank
	output logic o_acc_valid,
	output logic o_acc_write,
	output logic [axil_pkg::AXIL_ADDR_W-1:0] o_acc_addr,
	output logic [axil_pkg::AXIL_DATA_W-1:0] o_acc_wdata,
	output logic [axil_pkg::AXIL_STRB_W-1:0] o_acc_strb
);

	logic aw_full, w_full, ar_full;
	logic aw_full_d, w_full_d, ar_full_d;
	logic [axil_pkg::AXIL_ADDR_W-1:0] aw_addr;
	logic [axil_pkg::AXIL_ADDR_W-1:0] ar_addr;
	logic [axil_pkg::AXIL_DATA_W-1:0] w_data;
	logic [axil_pkg::AXIL_STRB_W-1:0] w_strb;
	logic aw_hs, w_hs, ar_hs;
	logic issue_wr, issue_rd;

	assign aw_hs = i_awvalid && o_awready;
	assign w_hs = i_wvalid && o_wready;
	assign ar_hs = i_arvalid && o_arready;

	// Write needs both halves held and a free B side
	assign issue_wr = aw_full && w_full && !i_b_busy;
	// Read only when no write goes out this cycle
	assign issue_rd = !issue_wr && ar_full && !i_r_busy;

	////////////////////////////////////////////////////////////
	// Slot occupancy
	////////////////////////////////////////////////////////////

	always_comb
	begin
		aw_full_d = aw_full;
		w_full_d = w_full;
		ar_full_d = ar_full;
		// Issue and fill never meet, ready is low while full
		if (issue_wr)
		begin
			aw_full_d = 1'b0;
			w_full_d = 1'b0;
		end
		else
		begin
			if (aw_hs)
				aw_full_d = 1'b1;
			if (w_hs)
				w_full_d = 1'b1;
		end
		if (issue_rd)
			ar_full_d = 1'b0;
		else if (ar_hs)
			ar_full_d = 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_full <= 1'b0;
			w_full <= 1'b0;
			ar_full <= 1'b0;
			// Ready stays low through reset
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_arready <= 1'b0;
		end
		else
		begin
			aw_full <= aw_full_d;
			w_full <= w_full_d;
			ar_full <= ar_full_d;
			// Ready mirrors an empty slot
			o_awready <= !aw_full_d;
			o_wready <= !w_full_d;
			o_arready <= !ar_full_d;
		end
	end

	// Slot payloads, captured on handshake
	always_ff @(posedge i_clk)
	begin
		if (aw_hs)
			aw_addr <= i_awaddr;
		if (w_hs)
		begin
			w_data <= i_wdata;
			w_strb <= i_wstrb;
		end
		if (ar_hs)
			ar_addr <= i_araddr;
	end

	////////////////////////////////////////////////////////////
	// Access strobe
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_acc_valid <= 1'b0;
		else
			o_acc_valid <= issue_wr || issue_rd;
	end

	always_ff @(posedge i_clk)
	begin
		o_acc_write <= issue_wr;
		o_acc_addr <= issue_wr ? aw_addr : ar_addr;
		o_acc_wdata <= w_data;
		o_acc_strb <= w_strb;
	end

	// An access in the bank stage holds its side busy, so no second one follows
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(o_acc_valid && o_acc_write) |-> i_b_busy);
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(o_acc_valid && !o_acc_write) |-> i_r_busy);

endmodule

`default_nettype wire

//--- hw/axil_resp_stage.sv
`timescale 1ns/100ps
`default_nettype none

module axil_resp_stage (
	input wire i_clk,
	input wire i_axi_reset_n,
	// Result from the bank
	input wire i_res_valid,
	input wire i_res_write,
	input wire [axil_pkg::AXIL_DATA_W-1:0] i_res_rdata,
	input wire [1:0] i_res_resp,
	// Access still in the bank stage
	input wire i_acc_valid,
	input wire i_acc_write,
	// Master ready
	input wire i_bready,
	input wire i_rready,
	// Write response channel
	output logic o_bvalid,
	output logic [1:0] o_bresp,
	// Read data channel
	output logic o_rvalid,
	output logic [axil_pkg::AXIL_DATA_W-1:0] o_rdata,
	output logic [1:0] o_rresp,
	// Stall back to the request stage
	output logic o_b_busy,
	output logic o_r_busy
);

	logic load_b, load_r;

	assign load_b = i_res_valid && i_res_write;
	assign load_r = i_res_valid && !i_res_write;

	// Busy covers the buffer and anything of that kind upstream
	assign o_b_busy = o_bvalid || (i_acc_valid && i_acc_write) || load_b;
	assign o_r_busy = o_rvalid || (i_acc_valid && !i_acc_write) || load_r;

	////////////////////////////////////////////////////////////
	// One-entry buffers
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end
		else
		begin
			// Load wins, busy keeps it away from a full buffer
			if (load_b)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;
			if (load_r)
				o_rvalid <= 1'b1;
			else if (i_rready)
				o_rvalid <= 1'b0;
		end
	end

	// Payload held until handshake
	always_ff @(posedge i_clk)
	begin
		if (load_b)
			o_bresp <= i_res_resp;
		if (load_r)
		begin
			o_rdata <= i_res_rdata;
			o_rresp <= i_res_resp;
		end
	end

	// A pending response is never replaced before its handshake
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		load_b |-> (!o_bvalid || i_bready));
	assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		load_r |-> (!o_rvalid || i_rready));

endmodule

`default_nettype wire

//--- test/tb_axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axil_regs;

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 3;
	localparam int CYCLES_PER_ENTRY = 40;
	localparam logic [31:0] SEED = 32'hf264ca26;
	// AW and W ordering of a write entry
	localparam logic [1:0] SKEW_NONE = 2'd0;
	localparam logic [1:0] SKEW_AW_FIRST = 2'd1;
	localparam logic [1:0] SKEW_W_FIRST = 2'd2;
	// Cycles the later half lags behind
	localparam int SKEW_CYCLES = 2;

	typedef struct packed {
		logic is_write;
		logic [1:0] skew;
		logic [axil_pkg::AXIL_ADDR_W-1:0] addr;
		logic [axil_pkg::AXIL_DATA_W-1:0] data;
		logic [axil_pkg::AXIL_STRB_W-1:0] strb;
		logic [axil_pkg::AXIL_DATA_W-1:0] exp_data;
		logic [1:0] exp_resp;
	} entry_t;

	logic clk;
	logic axi_reset_n;
	logic awvalid;
	logic awready;
	logic [axil_pkg::AXIL_ADDR_W-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [axil_pkg::AXIL_DATA_W-1:0] wdata;
	logic [axil_pkg::AXIL_STRB_W-1:0] wstrb;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [axil_pkg::AXIL_ADDR_W-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [axil_pkg::AXIL_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic [axil_pkg::OUTST_W-1:0] wr_outstanding;
	logic [axil_pkg::OUTST_W-1:0] rd_outstanding;

	entry_t tests[$];
	int entry_errors;
	int pass_count;
	int fail_count;

	axil_regs_top u_dut (
		.i_clk(clk),
		.i_axi_reset_n(axi_reset_n),
		.i_awvalid(awvalid),
		.o_awready(awready),
		.i_awaddr(awaddr),
		.i_wvalid(wvalid),
		.o_wready(wready),
		.i_wdata(wdata),
		.i_wstrb(wstrb),
		.o_bvalid(bvalid),
		.i_bready(bready),
		.o_bresp(bresp),
		.i_arvalid(arvalid),
		.o_arready(arready),
		.i_araddr(araddr),
		.o_rvalid(rvalid),
		.i_rready(rready),
		.o_rdata(rdata),
		.o_rresp(rresp),
		.o_wr_outstanding(wr_outstanding),
		.o_rd_outstanding(rd_outstanding)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////

	task automatic add_write(input logic [axil_pkg::AXIL_ADDR_W-1:0] addr,
		input logic [axil_pkg::AXIL_DATA_W-1:0] data,
		input logic [axil_pkg::AXIL_STRB_W-1:0] strb,
		input logic [1:0] skew, input logic [1:0] exp_resp);
		entry_t e;
		e.is_write = 1'b1;
		e.skew = skew;
		e.addr = addr;
		e.data = data;
		e.strb = strb;
		e.exp_data = '0;
		e.exp_resp = exp_resp;
		tests.push_back(e);
	endtask

	task automatic add_read(input logic [axil_pkg::AXIL_ADDR_W-1:0] addr,
		input logic [axil_pkg::AXIL_DATA_W-1:0] exp_data, input logic [1:0] exp_resp);
		entry_t e;
		e.is_write = 1'b0;
		e.skew = SKEW_NONE;
		e.addr = addr;
		e.data = '0;
		e.strb = '0;
		e.exp_data = exp_data;
		e.exp_resp = exp_resp;
		tests.push_back(e);
	endtask

	task automatic build_tests();
		// ID word, read-only
		add_read(8'h00, axil_pkg::REG_ID_VALUE, axil_pkg::RESP_OKAY);
		add_write(8'h00, 32'hffff_ffff, 4'hf, SKEW_NONE, axil_pkg::RESP_SLVERR);
		add_read(8'h00, axil_pkg::REG_ID_VALUE, axil_pkg::RESP_OKAY);
		// Full-strobe fill, skew rotates
		add_write(8'h04, 32'h1111_0001, 4'hf, SKEW_NONE, axil_pkg::RESP_OKAY);
		add_write(8'h08, 32'h2222_0002, 4'hf, SKEW_AW_FIRST, axil_pkg::RESP_OKAY);
		add_write(8'h0c, 32'h3333_0003, 4'hf, SKEW_W_FIRST, axil_pkg::RESP_OKAY);
		add_write(8'h10, 32'h4444_0004, 4'hf, SKEW_NONE, axil_pkg::RESP_OKAY);
		add_write(8'h14, 32'h5555_0005, 4'hf, SKEW_AW_FIRST, axil_pkg::RESP_OKAY);
		add_write(8'h18, 32'h6666_0006, 4'hf, SKEW_W_FIRST, axil_pkg::RESP_OKAY);
		add_write(8'h1f, 32'h7777_0007, 4'hf, SKEW_NONE, axil_pkg::RESP_OKAY);
		// Read back, some with low address bits set
		add_read(8'h05, 32'h1111_0001, axil_pkg::RESP_OKAY);
		add_read(8'h08, 32'h2222_0002, axil_pkg::RESP_OKAY);
		add_read(8'h0e, 32'h3333_0003, axil_pkg::RESP_OKAY);
		add_read(8'h10, 32'h4444_0004, axil_pkg::RESP_OKAY);
		add_read(8'h17, 32'h5555_0005, axil_pkg::RESP_OKAY);
		add_read(8'h18, 32'h6666_0006, axil_pkg::RESP_OKAY);
		add_read(8'h1c, 32'h7777_0007, axil_pkg::RESP_OKAY);
		// Partial strobes, bytes 0 and 2 of 0x3333_0003
		add_write(8'h0c, 32'haabb_ccdd, 4'b0101, SKEW_AW_FIRST, axil_pkg::RESP_OKAY);
		add_read(8'h0c, 32'h33bb_00dd, axil_pkg::RESP_OKAY);
		// Top byte only of 0x5555_0005
		add_write(8'h14, 32'h1234_5678, 4'b1000, SKEW_W_FIRST, axil_pkg::RESP_OKAY);
		add_read(8'h14, 32'h1255_0005, axil_pkg::RESP_OKAY);
		// No strobes, word untouched
		add_write(8'h18, 32'hdead_beef, 4'b0000, SKEW_NONE, axil_pkg::RESP_OKAY);
		add_read(8'h18, 32'h6666_0006, axil_pkg::RESP_OKAY);
		// Past the map
		add_read(8'h20, 32'h0000_0000, axil_pkg::RESP_DECERR);
		add_write(8'h20, 32'h0bad_0bad, 4'hf, SKEW_AW_FIRST, axil_pkg::RESP_DECERR);
		add_read(8'hfc, 32'h0000_0000, axil_pkg::RESP_DECERR);
		// Would alias word 1 if upper bits were dropped
		add_write(8'h84, 32'hcafe_f00d, 4'hf, SKEW_W_FIRST, axil_pkg::RESP_DECERR);
		add_read(8'h04, 32'h1111_0001, axil_pkg::RESP_OKAY);
		add_read(8'h00, axil_pkg::REG_ID_VALUE, axil_pkg::RESP_OKAY);
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_data(input string name,
		input logic [axil_pkg::AXIL_DATA_W-1:0] got,
		input logic [axil_pkg::AXIL_DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			entry_errors++;
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got,
		input logic [1:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			entry_errors++;
		end
	endtask

	task automatic check_count(input string name,
		input logic [axil_pkg::OUTST_W-1:0] got,
		input logic [axil_pkg::OUTST_W-1:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			entry_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////

	// Next edge, then the drive point just after it
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic write_entry(input entry_t e, output logic [1:0] resp);
		int aw_start;
		int w_start;
		int cycle;
		logic aw_done;
		logic w_done;
		logic aw_fire;
		logic w_fire;
		int ready_delay;
		aw_start = (e.skew == SKEW_W_FIRST) ? SKEW_CYCLES : 0;
		w_start = (e.skew == SKEW_AW_FIRST) ? SKEW_CYCLES : 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		cycle = 0;
		while (!(aw_done && w_done))
		begin
			if (!aw_done && cycle >= aw_start)
			begin
				awvalid = 1'b1;
				awaddr = e.addr;
			end
			if (!w_done && cycle >= w_start)
			begin
				wvalid = 1'b1;
				wdata = e.data;
				wstrb = e.strb;
			end
			// Ready is registered, so it is settled here
			aw_fire = awvalid && awready;
			w_fire = wvalid && wready;
			next_cycle();
			if (aw_fire)
			begin
				aw_done = 1'b1;
				awvalid = 1'b0;
			end
			if (w_fire)
			begin
				w_done = 1'b1;
				wvalid = 1'b0;
			end
			cycle++;
		end
		ready_delay = $urandom % 4;
		while (!bvalid)
			next_cycle();
		// Response must hold through the stall
		repeat (ready_delay)
			next_cycle();
		bready = 1'b1;
		resp = bresp;
		next_cycle();
		bready = 1'b0;
	endtask

	task automatic read_entry(input entry_t e, output logic [axil_pkg::AXIL_DATA_W-1:0] data,
		output logic [1:0] resp);
		logic ar_fire;
		int ready_delay;
		arvalid = 1'b1;
		araddr = e.addr;
		ar_fire = 1'b0;
		while (!ar_fire)
		begin
			ar_fire = arready;
			next_cycle();
		end
		arvalid = 1'b0;
		ready_delay = $urandom % 4;
		while (!rvalid)
			next_cycle();
		repeat (ready_delay)
			next_cycle();
		rready = 1'b1;
		data = rdata;
		resp = rresp;
		next_cycle();
		rready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic [axil_pkg::AXIL_DATA_W-1:0] got_data;
		logic [1:0] got_resp;
		void'($urandom(SEED));
		axi_reset_n = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		pass_count = 0;
		fail_count = 0;
		build_tests();
		repeat (RESET_CYCLES)
			@(posedge clk);
		#DRIVE_DELAY;
		axi_reset_n = 1'b1;
		// Valids stay low until an edge has seen reset released
		next_cycle();
		for (int i = 0; i < tests.size(); i++)
		begin
			entry_errors = 0;
			if (tests[i].is_write)
			begin
				write_entry(tests[i], got_resp);
				check_resp("o_bresp", got_resp, tests[i].exp_resp);
			end
			else
			begin
				read_entry(tests[i], got_data, got_resp);
				check_data("o_rdata", got_data, tests[i].exp_data);
				check_resp("o_rresp", got_resp, tests[i].exp_resp);
			end
			// Pipeline drained after each entry
			check_count("o_wr_outstanding", wr_outstanding, '0);
			check_count("o_rd_outstanding", rd_outstanding, '0);
			if (entry_errors == 0)
			begin
				pass_count++;
				$display("entry %0d %s addr 0x%h ok", i,
					tests[i].is_write ? "write" : "read", tests[i].addr);
			end
			else
			begin
				fail_count++;
				$display("entry %0d %s addr 0x%h had %0d mismatches", i,
					tests[i].is_write ? "write" : "read", tests[i].addr, entry_errors);
			end
		end
		$display("Entries run %0d, passed %0d, failed %0d",
			tests.size(), pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Watchdog, scaled by the number of table entries
	initial
	begin
		#DRIVE_DELAY;
		repeat (RESET_CYCLES + tests.size() * CYCLES_PER_ENTRY)
			@(posedge clk);
		$display("Timeout: the table did not complete in %0d cycles",
			RESET_CYCLES + tests.size() * CYCLES_PER_ENTRY);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/axil_pkg.sv
hw/axil_request_stage.sv
hw/axil_reg_bank.sv
hw/axil_resp_stage.sv
hw/axil_protocol_monitor.sv
hw/axil_regs_top.sv
test/tb_axil_regs.sv
